// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  // ========================================================================
  // Datapath widths
  // ========================================================================

  // Byte address into instruction memory
  typedef logic [31:0] addr_t;

  // One RV32I instruction word
  typedef logic [31:0] instr_t;

  // Major opcode field, instr[6:0]
  typedef logic [6:0] opcode_t;

  // Step between sequential fetches
  localparam addr_t instr_bytes = 32'd4;

  // addi x0, x0, 0, loaded into IF/ID on flush
  localparam instr_t nop_instr = 32'h0000_0013;

  // ========================================================================
  // Instruction classes
  // ========================================================================

  typedef enum logic [2:0] {
    class_alu     = 3'd0,
    class_load    = 3'd1,
    class_store   = 3'd2,
    class_branch  = 3'd3,
    class_jal     = 3'd4,
    class_jalr    = 3'd5,
    class_system  = 3'd6,
    class_illegal = 3'd7
  } instr_class_e;

  // RV32I major opcodes
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_auipc  = 7'b0010111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;
  localparam opcode_t op_system = 7'b1110011;

endpackage

`default_nettype wire

// ==== source/fetch_pc_seq.sv ====
`default_nettype none

module fetch_pc_seq #(
  parameter fetch_pkg::addr_t reset_pc = 32'h0000_0000
) (
  input  logic             clk,
  input  logic             rst_n,

  // Redirect from a later stage
  input  logic             flush,
  input  fetch_pkg::addr_t redirect_pc,

  // Advance when the fetch stage takes the current address
  input  logic             fetch_ready,
  output fetch_pkg::addr_t pc
);

  // ========================================================================
  // Next address selection
  // ========================================================================

  fetch_pkg::addr_t pc_seq;
  fetch_pkg::addr_t pc_next;

  // Sequential successor, one word on
  assign pc_seq = pc + fetch_pkg::instr_bytes;

  // Priority: redirect, then advance, else hold
  always_comb begin
    if (flush) begin
      pc_next = redirect_pc;
    end else if (fetch_ready) begin
      pc_next = pc_seq;
    end else begin
      pc_next = pc;
    end
  end

  // ========================================================================
  // Fetch address register
  // ========================================================================

  // Boot address comes from the top level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
`default_nettype none

module fetch_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,

  // Address from the PC sequencer
  input  fetch_pkg::addr_t  pc,
  output logic              fetch_ready,

  // Synchronous instruction memory, one cycle read latency
  output logic              imem_arvalid,
  output fetch_pkg::addr_t  imem_araddr,
  input  fetch_pkg::instr_t imem_rdata,
  input  logic              imem_rvalid,

  // IF/ID register towards the predecoder
  output logic              if_valid,
  output fetch_pkg::addr_t  if_pc,
  output fetch_pkg::instr_t if_instr,
  input  logic              id_ready
);

  logic              flush_extend;
  logic              kill;
  fetch_pkg::addr_t  pc_buf;
  logic              rsp_hold_valid;
  fetch_pkg::instr_t rsp_hold_data;
  logic              rsp_valid;
  fetch_pkg::instr_t rsp_data;

  // ========================================================================
  // Memory request
  // ========================================================================

  // Back-pressure from the predecoder stops requests and PC advance
  assign fetch_ready  = id_ready;
  assign imem_arvalid = id_ready;
  assign imem_araddr  = pc;

  // Address of the request in flight, lines up with the returning word
  always_ff @(posedge clk) begin
    if (id_ready) begin
      pc_buf <= imem_araddr;
    end
  end

  // ========================================================================
  // Extended flush
  // ========================================================================

  // The sequential word requested in the flush cycle returns one cycle
  // later and has to be dropped as well
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flush_extend <= 1'b0;
    end else begin
      flush_extend <= flush;
    end
  end

  assign kill = flush || flush_extend;

  // ========================================================================
  // Response holding
  // ========================================================================

  // A word that lands while IF/ID is stalled waits here until capture
  always_ff @(posedge clk) begin
    if (!rst_n || kill) begin
      rsp_hold_valid <= 1'b0;
    end else if (id_ready) begin
      rsp_hold_valid <= 1'b0;
    end else if (imem_rvalid) begin
      rsp_hold_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!id_ready && imem_rvalid) begin
      rsp_hold_data <= imem_rdata;
    end
  end

  // Held word first, it is the older one
  assign rsp_valid = rsp_hold_valid || imem_rvalid;
  assign rsp_data  = rsp_hold_valid ? rsp_hold_data : imem_rdata;

  // ========================================================================
  // IF/ID register
  // ========================================================================

  // Valid follows the response on every accepted edge
  always_ff @(posedge clk) begin
    if (!rst_n || kill) begin
      if_valid <= 1'b0;
    end else if (id_ready) begin
      if_valid <= rsp_valid;
    end
  end

  // Bubble word on reset and flush
  always_ff @(posedge clk) begin
    if (!rst_n || kill) begin
      if_instr <= fetch_pkg::nop_instr;
    end else if (id_ready && rsp_valid) begin
      if_instr <= rsp_data;
    end
  end

  // PC of the word, only meaningful while if_valid is high
  always_ff @(posedge clk) begin
    if (id_ready) begin
      if_pc <= pc_buf;
    end
  end

endmodule

`default_nettype wire

// ==== source/instr_predecode.sv ====
`default_nettype none

module instr_predecode (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush,

  // From the IF/ID register
  input  logic                    if_valid,
  input  fetch_pkg::addr_t        if_pc,
  input  fetch_pkg::instr_t       if_instr,
  output logic                    id_ready,

  // Registered result towards the decode stage
  output logic                    out_valid,
  input  logic                    out_ready,
  output fetch_pkg::addr_t        out_pc,
  output fetch_pkg::instr_t       out_instr,
  output fetch_pkg::instr_class_e out_class,
  output fetch_pkg::addr_t        out_target
);

  fetch_pkg::opcode_t      opcode;
  fetch_pkg::instr_class_e dec_class;
  fetch_pkg::addr_t        imm_b;
  fetch_pkg::addr_t        imm_j;
  fetch_pkg::addr_t        dec_target;

  // ========================================================================
  // Classification
  // ========================================================================

  assign opcode = if_instr[6:0];

  // Every major opcode ends in 11, so compressed encodings land in default
  always_comb begin
    case (opcode)
      fetch_pkg::op_lui,
      fetch_pkg::op_auipc,
      fetch_pkg::op_imm,
      fetch_pkg::op_reg:    dec_class = fetch_pkg::class_alu;
      fetch_pkg::op_load:   dec_class = fetch_pkg::class_load;
      fetch_pkg::op_store:  dec_class = fetch_pkg::class_store;
      fetch_pkg::op_branch: dec_class = fetch_pkg::class_branch;
      fetch_pkg::op_jal:    dec_class = fetch_pkg::class_jal;
      fetch_pkg::op_jalr:   dec_class = fetch_pkg::class_jalr;
      fetch_pkg::op_system: dec_class = fetch_pkg::class_system;
      default:              dec_class = fetch_pkg::class_illegal;
    endcase
  end

  // ========================================================================
  // Static target
  // ========================================================================

  // B-type offset, 13 bits with bit 0 zero
  assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                  if_instr[30:25], if_instr[11:8], 1'b0};

  // J-type offset, 21 bits with bit 0 zero
  assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                  if_instr[20], if_instr[30:21], 1'b0};

  // jalr needs rs1, so it falls back to the sequential address
  always_comb begin
    case (dec_class)
      fetch_pkg::class_branch: dec_target = if_pc + imm_b;
      fetch_pkg::class_jal:    dec_target = if_pc + imm_j;
      default:                 dec_target = if_pc + fetch_pkg::instr_bytes;
    endcase
  end

  // ========================================================================
  // Output register
  // ========================================================================

  // Take a new word when the slot is empty or drains this cycle
  assign id_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      out_valid <= 1'b0;
    end else if (id_ready) begin
      out_valid <= if_valid;
    end
  end

  // Payload holds while stalled
  always_ff @(posedge clk) begin
    if (id_ready && if_valid) begin
      out_pc     <= if_pc;
      out_instr  <= if_instr;
      out_class  <= dec_class;
      out_target <= dec_target;
    end
  end

endmodule

`default_nettype wire

// ==== source/fetch_top.sv ====
`default_nettype none

module fetch_top #(
  parameter fetch_pkg::addr_t reset_pc = 32'h0000_0000
) (
  input  logic                    clk,
  input  logic                    rst_n,

  // Redirect from branch resolution
  input  logic                    redirect_valid,
  input  fetch_pkg::addr_t        redirect_pc,

  // Instruction memory
  output logic                    imem_arvalid,
  output fetch_pkg::addr_t        imem_araddr,
  input  fetch_pkg::instr_t       imem_rdata,
  input  logic                    imem_rvalid,

  // Predecoded output
  output logic                    out_valid,
  input  logic                    out_ready,
  output fetch_pkg::addr_t        out_pc,
  output fetch_pkg::instr_t       out_instr,
  output fetch_pkg::instr_class_e out_class,
  output fetch_pkg::addr_t        out_target
);

  // Sequencer to fetch stage
  fetch_pkg::addr_t  pc;
  logic              fetch_ready;

  // Fetch stage to predecoder
  logic              if_valid;
  fetch_pkg::addr_t  if_pc;
  fetch_pkg::instr_t if_instr;
  logic              id_ready;

  // ========================================================================
  // Pipeline
  // ========================================================================

  // Redirect flushes all three blocks at once
  fetch_pc_seq #(
    .reset_pc(reset_pc)
  ) u_pc_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (redirect_valid),
    .redirect_pc(redirect_pc),
    .fetch_ready(fetch_ready),
    .pc         (pc)
  );

  fetch_stage u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (redirect_valid),
    .pc          (pc),
    .fetch_ready (fetch_ready),
    .imem_arvalid(imem_arvalid),
    .imem_araddr (imem_araddr),
    .imem_rdata  (imem_rdata),
    .imem_rvalid (imem_rvalid),
    .if_valid    (if_valid),
    .if_pc       (if_pc),
    .if_instr    (if_instr),
    .id_ready    (id_ready)
  );

  instr_predecode u_predecode (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (redirect_valid),
    .if_valid  (if_valid),
    .if_pc     (if_pc),
    .if_instr  (if_instr),
    .id_ready  (id_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_pc    (out_pc),
    .out_instr (out_instr),
    .out_class (out_class),
    .out_target(out_target)
  );

endmodule

`default_nettype wire

// ==== testbench/fetch_top_checker.sv ====
`default_nettype none

module fetch_top_checker (
  input logic                    clk,
  input logic                    rst_n,
  input logic                    redirect_valid,
  input logic                    imem_arvalid,
  input fetch_pkg::addr_t        imem_araddr,
  input logic                    out_valid,
  input logic                    out_ready,
  input fetch_pkg::addr_t        out_pc,
  input fetch_pkg::instr_t       out_instr,
  input fetch_pkg::instr_class_e out_class,
  input fetch_pkg::addr_t        out_target
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions so far, read by the testbench
  int error_count = 0;

  // ========================================================================
  // Output handshake
  // ========================================================================

  // Stalled output stays valid unless a redirect flushes it
  a_valid_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready && !redirect_valid) |=> out_valid)
    else begin
      $error("out_valid dropped while stalled");
      error_count++;
    end

  // Payload frozen under stall
  a_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready && !redirect_valid) |=>
      ($stable(out_pc) && $stable(out_instr) && $stable(out_class) && $stable(out_target)))
    else begin
      $error("Output payload changed while stalled");
      error_count++;
    end

  // Pipe still empty in the first cycle out of reset
  a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset release");
      error_count++;
    end

  // ========================================================================
  // Memory request
  // ========================================================================

  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imem_arvalid |-> (imem_araddr[1:0] == 2'b00))
    else begin
      $error("imem_araddr not word aligned");
      error_count++;
    end

endmodule

`default_nettype wire

// ==== testbench/fetch_top_tb.sv ====
`default_nettype none

module fetch_top_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int               clk_period     = 100;
  localparam fetch_pkg::addr_t boot_pc        = 32'h0000_0200;
  localparam int               image_words    = 32;
  localparam int               steady_outputs = 10;
  localparam int               max_redirects  = 8;

  logic                    clk;
  logic                    rst_n;
  logic                    redirect_valid;
  fetch_pkg::addr_t        redirect_pc;
  logic                    imem_arvalid;
  fetch_pkg::addr_t        imem_araddr;
  fetch_pkg::instr_t       imem_rdata;
  logic                    imem_rvalid;
  logic                    out_valid;
  logic                    out_ready;
  fetch_pkg::addr_t        out_pc;
  fetch_pkg::instr_t       out_instr;
  fetch_pkg::instr_class_e out_class;
  fetch_pkg::addr_t        out_target;

  // Cases file contents
  logic [31:0]       cases [0:63];
  fetch_pkg::instr_t image [0:image_words-1];
  fetch_pkg::addr_t  base_pc;
  int                total_outputs;
  int                redirects;
  int                redir_at [0:max_redirects-1];
  fetch_pkg::addr_t  redir_to [0:max_redirects-1];

  // Memory model state
  logic              req_pending;
  fetch_pkg::addr_t  req_addr;
  logic [31:0]       lcg_state;

  // ========================================================================
  // DUT, checker and clock
  // ========================================================================

  fetch_top #(
    .reset_pc(boot_pc)
  ) dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_valid(redirect_valid),
    .redirect_pc   (redirect_pc),
    .imem_arvalid  (imem_arvalid),
    .imem_araddr   (imem_araddr),
    .imem_rdata    (imem_rdata),
    .imem_rvalid   (imem_rvalid),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_pc        (out_pc),
    .out_instr     (out_instr),
    .out_class     (out_class),
    .out_target    (out_target)
  );

  bind fetch_top fetch_top_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_valid(redirect_valid),
    .imem_arvalid  (imem_arvalid),
    .imem_araddr   (imem_araddr),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_pc        (out_pc),
    .out_instr     (out_instr),
    .out_class     (out_class),
    .out_target    (out_target)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Requests seen at the rising edge, answered on the next falling edge
  always @(posedge clk) begin
    req_pending <= rst_n && imem_arvalid;
    req_addr    <= imem_araddr;
  end

  // ========================================================================
  // Reference model
  // ========================================================================

  // Image word, or an address-derived fill outside the image
  function automatic fetch_pkg::instr_t image_word(input fetch_pkg::addr_t addr);
    fetch_pkg::addr_t offset;
    offset = addr - base_pc;
    if (offset < image_words * 4) begin
      return image[offset[6:2]];
    end
    return addr ^ 32'hc3a5_5a3c;
  endfunction

  // RV32I opcode map, row and column of instr[6:2]
  function automatic fetch_pkg::instr_class_e expected_class(input fetch_pkg::instr_t word);
    if (word[1:0] != 2'b11) begin
      return fetch_pkg::class_illegal;
    end
    case (word[6:2])
      5'b01101, 5'b00101, 5'b00100, 5'b01100: return fetch_pkg::class_alu;
      5'b00000: return fetch_pkg::class_load;
      5'b01000: return fetch_pkg::class_store;
      5'b11000: return fetch_pkg::class_branch;
      5'b11011: return fetch_pkg::class_jal;
      5'b11001: return fetch_pkg::class_jalr;
      5'b11100: return fetch_pkg::class_system;
      default:  return fetch_pkg::class_illegal;
    endcase
  endfunction

  // Branch and JAL jump by the immediate, all others fall through
  function automatic fetch_pkg::addr_t expected_target(input fetch_pkg::addr_t pc,
                                                       input fetch_pkg::instr_t word);
    fetch_pkg::addr_t offset;
    case (expected_class(word))
      fetch_pkg::class_branch:
        offset = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
      fetch_pkg::class_jal:
        offset = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
      default:
        offset = 32'd4;
    endcase
    return pc + offset;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // ========================================================================
  // Checks
  // ========================================================================

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic compare_addr(input string name, input fetch_pkg::addr_t expected,
                              input fetch_pkg::addr_t actual);
    if (actual !== expected) begin
      stop_run($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_instr(input string name, input fetch_pkg::instr_t expected,
                               input fetch_pkg::instr_t actual);
    if (actual !== expected) begin
      stop_run($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_class(input string name, input fetch_pkg::instr_class_e expected,
                               input fetch_pkg::instr_class_e actual);
    if (actual !== expected) begin
      stop_run($sformatf("ERROR %s: expected %s, actual %s", name, expected.name(),
                         actual.name()));
    end
  endtask

  task automatic check_output(input int index, input fetch_pkg::addr_t pc);
    fetch_pkg::instr_t word;
    word = image_word(pc);
    compare_addr($sformatf("output %0d pc", index), pc, out_pc);
    compare_instr($sformatf("output %0d instr", index), word, out_instr);
    compare_class($sformatf("output %0d class", index), expected_class(word), out_class);
    compare_addr($sformatf("output %0d target", index), expected_target(pc, word), out_target);
  endtask

  task automatic drive_memory();
    imem_rvalid = req_pending;
    imem_rdata  = req_pending ? image_word(req_addr) : 32'h0;
  endtask

  // ========================================================================
  // Stimulus
  // ========================================================================

  initial begin
    int               i;
    int               cycle;
    int               accepted;
    int               redir_idx;
    int               timeout_cycles;
    fetch_pkg::addr_t expected_pc;

    rst_n          = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    imem_rdata     = '0;
    imem_rvalid    = 1'b0;
    out_ready      = 1'b1;
    lcg_state      = 32'h955d_84b7;

    // Header, image, then redirect pairs
    $readmemh("testbench/fetch_cases.mem", cases);
    if ($isunknown(cases[0]) || $isunknown(cases[1]) || $isunknown(cases[2])) begin
      stop_run("The cases file is missing or its header is incomplete");
    end
    base_pc       = cases[0];
    total_outputs = cases[1];
    redirects     = cases[2];
    if (base_pc !== boot_pc || redirects > max_redirects || total_outputs == 0) begin
      stop_run("The cases file header does not fit this testbench");
    end
    for (i = 0; i < image_words; i++) begin
      image[i] = cases[3 + i];
    end
    for (i = 0; i < redirects; i++) begin
      redir_at[i] = cases[35 + 2 * i];
      redir_to[i] = cases[36 + 2 * i];
    end
    timeout_cycles = total_outputs * 4 + redirects * 8 + 50;

    // Reset held for 4 rising edges
    repeat (4) begin
      @(negedge clk);
      drive_memory();
      if (out_valid !== 1'b0 || imem_arvalid !== 1'b1) begin
        stop_run("During reset out_valid was not low or imem_arvalid was not high");
      end
    end
    rst_n = 1'b1;

    cycle       = 0;
    accepted    = 0;
    redir_idx   = 0;
    expected_pc = base_pc;
    while (accepted < total_outputs) begin
      @(negedge clk);
      cycle++;
      drive_memory();
      if (cycle > timeout_cycles) begin
        stop_run("The run ran out of time before all outputs were accepted");
      end
      if (dut0.u_checker.error_count != 0) begin
        stop_run("An assertion in the checker failed");
      end
      // First request at the edge after release, output 3 edges on
      if (cycle < 3 && out_valid !== 1'b0) begin
        stop_run("out_valid rose earlier than 3 cycles after the first request");
      end
      if (cycle == 3 && out_valid !== 1'b1) begin
        stop_run("out_valid did not rise 3 cycles after the first request");
      end
      if (redir_idx < redirects && accepted == redir_at[redir_idx]) begin
        // Output in the flush cycle is squashed and not counted
        // Ready high lets the stale request of this cycle go out
        redirect_valid = 1'b1;
        redirect_pc    = redir_to[redir_idx];
        out_ready      = 1'b1;
        expected_pc    = redir_to[redir_idx];
        redir_idx++;
      end else begin
        redirect_valid = 1'b0;
        if (accepted < steady_outputs) begin
          out_ready = 1'b1;
        end else begin
          lcg_state = lcg_next(lcg_state);
          out_ready = lcg_state[31];
        end
        // Transfer happens at the coming rising edge
        if (out_valid && out_ready) begin
          check_output(accepted, expected_pc);
          expected_pc = expected_pc + 32'd4;
          accepted++;
        end
      end
    end

    @(negedge clk);
    if (dut0.u_checker.error_count != 0) begin
      stop_run("An assertion in the checker failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/fetch_cases.mem ====
// One hex value each: reset address, outputs to check, redirect count,
// 32 image words from the reset address on, then per redirect the
// accepted output count and the target address
00000200
0000002e
00000003
// 0x200 nop, addi, lui, auipc
00000013 00500093 000100b7 00002117
// 0x210 add, lw, sw, beq +8
002081b3 0000a203 0040a423 00208463
// 0x220 bne -4, jal +12, jal -16, jalr
fe209ee3 00c0006f ff1ff0ef 000080e7
// 0x230 ecall, ebreak, two illegal words
00000073 00100073 ffffffff 00000000
// 0x240 compressed quadrant, custom-0, beq -4, jal -1 MiB
12345002 0000000b fe000ee3 8000006f
// 0x250 addi, sub, lw -4, sw -4
7ff00093 40208133 ffc12283 fe512e23
// 0x260 beq +4094, beq -4096, jal +16, jalr
7e000fe3 80000063 0100006f 00008067
// 0x270 mret, fence (not in the table), illegal, nop
30200073 0ff0000f 0000107f 00000013
// Redirects
0000000a 00000240
00000016 00000208
00000022 00000250

// ==== filelist.f ====
source/fetch_pkg.sv
source/fetch_pc_seq.sv
source/fetch_stage.sv
source/instr_predecode.sv
source/fetch_top.sv
testbench/fetch_top_checker.sv
testbench/fetch_top_tb.sv
